//--- common/cpu_defs.svh
// frame phase numbers, opcode values and reset pc, included by the rtl and the testbench
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// pin frame, counted in clk cycles from the idle phase
`define FRAME_LEN      10
`define PHASE_FLAG     5    // read/write flag on uo_out[0]
`define PHASE_RD_FIRST 6    // first read byte on uio_in

// opcode field, instr[31:28]
`define OP_LOADI 4'd0
`define OP_ADD   4'd1
`define OP_XOR   4'd2
`define OP_LOAD  4'd3
`define OP_STORE 4'd4
`define OP_JUMP  4'd5
`define OP_JZ    4'd6
`define OP_HALT  4'd15

// first fetch address
`define RESET_PC 32'h0000_0000

`endif

//--- common/cpu_pkg.sv
// types shared by the accumulator cpu and the bus handler, imported by every rtl module
`default_nettype none

package cpu_pkg;

  typedef logic [31:0] word_t;      // data or instruction word
  typedef logic [31:0] addr_t;      // byte address
  typedef logic [7:0]  pin_byte_t;  // one tile pin group

  typedef logic [3:0]  opcode_t;    // instr[31:28]
  typedef logic [15:0] imm_t;       // instr[15:0], zero-extended where used

  // pin frame sequencer
  typedef enum logic [1:0] {
    fs_idle,      // phase 0
    fs_addr_out,  // phases 1 to 4
    fs_flag_out,  // phase 5
    fs_data_in    // phases 6 to 9
  } frame_state_t;

  // cpu step state
  typedef enum logic [1:0] {
    cs_fetch,
    cs_mem_access,  // second frame of load and store
    cs_halted
  } cpu_state_t;

endpackage

`default_nettype wire

//--- cpu/cpu_decode.sv
// instruction decoder of the accumulator cpu, splits the fetched word into fields and flags
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module cpu_decode
  import cpu_pkg::*;
(
  input  word_t   instr,
  output opcode_t opcode,
  output imm_t    imm,
  output logic    is_mem,
  output logic    is_store,
  output logic    is_branch,
  output logic    is_halt
);

  assign opcode = instr[31:28];
  assign imm    = instr[15:0];  // bits 27:16 are reserved

  // class flags, unknown opcodes fall through as no-ops
  always_comb begin
    is_mem    = 1'b0;
    is_store  = 1'b0;
    is_branch = 1'b0;
    is_halt   = 1'b0;
    case (opcode)
      `OP_LOAD: begin
        is_mem = 1'b1;
      end
      `OP_STORE: begin
        is_mem   = 1'b1;
        is_store = 1'b1;
      end
      `OP_JUMP, `OP_JZ: begin
        is_branch = 1'b1;
      end
      `OP_HALT: begin
        is_halt = 1'b1;
      end
      default: begin
        // alu ops and no-ops raise no flag
      end
    endcase
  end

endmodule

`default_nettype wire

//--- cpu/cpu_execute.sv
// execute stage of the accumulator cpu, forms next state and the next bus request
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module cpu_execute
  import cpu_pkg::*;
(
  input  opcode_t    opcode,
  input  imm_t       imm,
  input  logic       is_mem,
  input  logic       is_store,
  input  logic       is_branch,
  input  logic       is_halt,
  input  word_t      acc,
  input  addr_t      pc,
  input  cpu_state_t state,
  input  word_t      bus_rdata,
  output word_t      acc_next,
  output addr_t      pc_next,
  output cpu_state_t state_next,
  output addr_t      req_addr,
  output word_t      req_wdata,
  output logic       req_write,
  output logic       instr_load
);

  word_t imm_ext;
  addr_t pc_plus4;
  word_t alu_out;

  assign imm_ext    = {16'h0000, imm};
  assign pc_plus4   = pc + 32'd4;
  assign instr_load = (state == cs_fetch);  // fetched word arrives on this step

  always_comb begin
    case (opcode)
      `OP_LOADI: alu_out = imm_ext;
      `OP_ADD:   alu_out = acc + imm_ext;  // wraps at 32 bits
      `OP_XOR:   alu_out = acc ^ imm_ext;
      default:   alu_out = acc;
    endcase
  end

  always_comb begin
    acc_next   = acc;
    pc_next    = pc;
    state_next = state;
    req_addr   = pc;
    req_wdata  = acc;
    req_write  = 1'b0;
    case (state)
      cs_fetch: begin
        if (is_halt) begin
          state_next = cs_halted;
        end else if (is_mem) begin
          // data frame at the immediate address, then fetch pc+4
          pc_next    = pc_plus4;
          state_next = cs_mem_access;
          req_addr   = imm_ext;
          req_write  = is_store;
        end else if (is_branch) begin
          pc_next  = (opcode == `OP_JZ && acc != '0) ? pc_plus4 : imm_ext;
          req_addr = pc_next;
        end else begin
          acc_next = alu_out;
          pc_next  = pc_plus4;
          req_addr = pc_plus4;
        end
      end
      cs_mem_access: begin
        if (!is_store) begin
          acc_next = bus_rdata;  // load result
        end
        state_next = cs_fetch;
      end
      default: begin
        // halted holds everything
      end
    endcase
  end

endmodule

`default_nettype wire

//--- cpu/cpu_result.sv
// result stage of the accumulator cpu, holds architectural state and the pending bus request
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module cpu_result
  import cpu_pkg::*;
(
  input  logic       clk,
  input  logic       rst_n,
  input  logic       step,
  input  word_t      acc_next,
  input  addr_t      pc_next,
  input  cpu_state_t state_next,
  input  addr_t      req_addr,
  input  word_t      req_wdata,
  input  logic       req_write,
  input  logic       instr_load,
  input  word_t      bus_rdata,
  output word_t      acc,
  output addr_t      pc,
  output cpu_state_t state,
  output word_t      instr,
  output addr_t      bus_addr,
  output word_t      bus_wdata,
  output logic       bus_write,
  output logic       halted
);

  word_t instr_q;  // instruction under a data access

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      acc       <= '0;
      pc        <= `RESET_PC;
      state     <= cs_fetch;
      bus_addr  <= `RESET_PC;  // first frame fetches the reset pc
      bus_wdata <= '0;
      bus_write <= 1'b0;
    end else if (step) begin
      acc       <= acc_next;
      pc        <= pc_next;
      state     <= state_next;
      bus_addr  <= req_addr;
      bus_wdata <= req_wdata;
      bus_write <= req_write;
    end
  end

  always_ff @(posedge clk) begin
    if (step && instr_load) begin
      instr_q <= bus_rdata;
    end
  end

  // decode straight from the bus on a fetch step
  assign instr  = instr_load ? bus_rdata : instr_q;
  assign halted = (state == cs_halted);

endmodule

`default_nettype wire

//--- cpu/cpu_core.sv
// accumulator cpu, decode and execute feeding the result registers, driven by the bus step
`timescale 1ns/1ps
`default_nettype none

module cpu_core
  import cpu_pkg::*;
(
  input  logic  clk,
  input  logic  rst_n,
  input  logic  step,
  input  word_t bus_rdata,
  output addr_t bus_addr,
  output word_t bus_wdata,
  output logic  bus_write,
  output logic  halted
);

  word_t      instr;
  opcode_t    opcode;
  imm_t       imm;
  logic       is_mem;
  logic       is_store;
  logic       is_branch;
  logic       is_halt;
  word_t      acc;
  addr_t      pc;
  cpu_state_t state;
  word_t      acc_next;
  addr_t      pc_next;
  cpu_state_t state_next;
  addr_t      req_addr;
  word_t      req_wdata;
  logic       req_write;
  logic       instr_load;

  cpu_decode u_decode (
    .instr     (instr),
    .opcode    (opcode),
    .imm       (imm),
    .is_mem    (is_mem),
    .is_store  (is_store),
    .is_branch (is_branch),
    .is_halt   (is_halt)
  );

  cpu_execute u_execute (
    .opcode     (opcode),
    .imm        (imm),
    .is_mem     (is_mem),
    .is_store   (is_store),
    .is_branch  (is_branch),
    .is_halt    (is_halt),
    .acc        (acc),
    .pc         (pc),
    .state      (state),
    .bus_rdata  (bus_rdata),
    .acc_next   (acc_next),
    .pc_next    (pc_next),
    .state_next (state_next),
    .req_addr   (req_addr),
    .req_wdata  (req_wdata),
    .req_write  (req_write),
    .instr_load (instr_load)
  );

  cpu_result u_result (
    .clk        (clk),
    .rst_n      (rst_n),
    .step       (step),
    .acc_next   (acc_next),
    .pc_next    (pc_next),
    .state_next (state_next),
    .req_addr   (req_addr),
    .req_wdata  (req_wdata),
    .req_write  (req_write),
    .instr_load (instr_load),
    .bus_rdata  (bus_rdata),
    .acc        (acc),
    .pc         (pc),
    .state      (state),
    .instr      (instr),
    .bus_addr   (bus_addr),
    .bus_wdata  (bus_wdata),
    .bus_write  (bus_write),
    .halted     (halted)
  );

endmodule

`default_nettype wire

//--- source/bus_handler.sv
// byte-serial frame sequencer, moves one 32-bit cpu bus transaction over the tile pins
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module bus_handler
  import cpu_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  logic      run,
  input  pin_byte_t uio_in,
  output pin_byte_t uo_out,
  output pin_byte_t uio_out,
  output pin_byte_t uio_oe,
  input  addr_t     bus_addr,
  input  word_t     bus_wdata,
  input  logic      bus_write,
  input  logic      halted,
  output word_t     bus_rdata,
  output logic      step
);

  frame_state_t state;
  logic [3:0]   phase;    // 0 idle, 1..9 inside a frame
  logic [23:0]  rd_low;   // read bytes 0 to 2
  logic [1:0]   rd_sel;
  logic [1:0]   out_sel;
  logic         last_phase;

  assign last_phase = (phase == 4'(`FRAME_LEN - 1));
  assign rd_sel     = 2'(phase - 4'(`PHASE_RD_FIRST));
  assign out_sel    = 2'(phase - 4'd1);  // byte lane for phases 1 to 4

  // frame sequencer, run is only looked at in idle
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= fs_idle;
      phase <= '0;
    end else begin
      case (state)
        fs_idle: begin
          if (run && !halted) begin
            state <= fs_addr_out;
            phase <= 4'd1;
          end
        end
        fs_addr_out: begin
          phase <= phase + 4'd1;
          if (phase == 4'(`PHASE_FLAG - 1)) begin
            state <= fs_flag_out;
          end
        end
        fs_flag_out: begin
          phase <= phase + 4'd1;
          state <= fs_data_in;
        end
        fs_data_in: begin
          if (last_phase) begin
            state <= fs_idle;
            phase <= '0;
          end else begin
            phase <= phase + 4'd1;
          end
        end
        default: begin
          state <= fs_idle;
          phase <= '0;
        end
      endcase
    end
  end

  // read bytes sampled on the edge that closes their phase
  always_ff @(posedge clk) begin
    if (state == fs_data_in) begin
      case (rd_sel)
        2'd0:    rd_low[7:0]   <= uio_in;
        2'd1:    rd_low[15:8]  <= uio_in;
        2'd2:    rd_low[23:16] <= uio_in;
        default: begin
          // last byte goes straight to the cpu
        end
      endcase
    end
  end

  // step on the last phase, the cpu commits on the edge that ends the frame
  assign step      = (state == fs_data_in) && last_phase;
  assign bus_rdata = {uio_in, rd_low};

  always_comb begin
    uo_out  = '0;
    uio_out = '0;
    uio_oe  = '0;
    case (state)
      fs_idle: begin
        if (halted) begin
          uo_out = 8'h80;  // halt marker
        end
      end
      fs_addr_out: begin
        uo_out  = bus_addr[{out_sel, 3'b000} +: 8];
        uio_out = bus_wdata[{out_sel, 3'b000} +: 8];
        uio_oe  = {8{bus_write}};  // drive data pins on writes only
      end
      fs_flag_out: begin
        uo_out = {7'b0000000, bus_write};
      end
      default: begin
        // memory drives uio_in
      end
    endcase
  end

endmodule

`default_nettype wire

//--- source/cpu_handler_top.sv
// chip top with the tile pin set, joins the bus handler to the accumulator cpu
`timescale 1ns/1ps
`default_nettype none

module cpu_handler_top
  import cpu_pkg::*;
(
  input  logic      clk,
  input  logic      rst_n,
  input  pin_byte_t ui_in,    // bit 0 is run
  input  pin_byte_t uio_in,
  input  logic      ena,      // tile enable, always high when powered
  output pin_byte_t uo_out,
  output pin_byte_t uio_out,
  output pin_byte_t uio_oe
);

  addr_t bus_addr;
  word_t bus_wdata;
  logic  bus_write;
  logic  halted;
  word_t bus_rdata;
  logic  step;

  bus_handler u_bus_handler (
    .clk       (clk),
    .rst_n     (rst_n),
    .run       (ui_in[0]),
    .uio_in    (uio_in),
    .uo_out    (uo_out),
    .uio_out   (uio_out),
    .uio_oe    (uio_oe),
    .bus_addr  (bus_addr),
    .bus_wdata (bus_wdata),
    .bus_write (bus_write),
    .halted    (halted),
    .bus_rdata (bus_rdata),
    .step      (step)
  );

  cpu_core u_cpu_core (
    .clk       (clk),
    .rst_n     (rst_n),
    .step      (step),
    .bus_rdata (bus_rdata),
    .bus_addr  (bus_addr),
    .bus_wdata (bus_wdata),
    .bus_write (bus_write),
    .halted    (halted)
  );

endmodule

`default_nettype wire

//--- verification/cpu_handler_asserts.sv
// concurrent checks on the pin frame of the bus handler, bound into bus_handler by the testbench
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module cpu_handler_asserts
  import cpu_pkg::*;
(
  input logic       clk,
  input logic       rst_n,
  input logic [3:0] phase,
  input pin_byte_t  uio_oe,
  input logic       step
);

  int fail_count = 0;  // failed checks so far

  // memory owns the data pins from the flag phase on
  oe_off_after_addr: assert property (
    @(posedge clk) disable iff (!rst_n) (phase >= 4'(`PHASE_FLAG)) |-> (uio_oe == 8'h00)
  ) else begin
    fail_count = fail_count + 1;
    $error("uio_oe is %h in phase %0d", uio_oe, phase);
  end

  phase_in_range: assert property (
    @(posedge clk) disable iff (!rst_n) phase <= 4'(`FRAME_LEN - 1)
  ) else begin
    fail_count = fail_count + 1;
    $error("phase counter at %0d", phase);
  end

  step_one_cycle: assert property (
    @(posedge clk) disable iff (!rst_n) step |=> !step
  ) else begin
    fail_count = fail_count + 1;
    $error("step held for two cycles");
  end

endmodule

`default_nettype wire

//--- verification/tb_cpu_handler.sv
// testbench for the tile cpu, plays the external memory on the byte pins and checks each frame
`timescale 1ns/1ps
`default_nettype none

`include "cpu_defs.svh"

module tb_cpu_handler
  import cpu_pkg::*;
();

  localparam int RESET_CYCLES = 10;
  localparam int CNT_BASE     = 'h40;  // frame, write and stall counts
  localparam int WR_BASE      = 'h44;  // expected (addr, data) pairs
  localparam int STALL_BASE   = 'h50;  // (frame index, idle cycles) pairs
  localparam int ADDR_BASE    = 'h60;  // expected address of every frame
  localparam int HALT_CYCLES  = 3 * `FRAME_LEN;

  logic      clk = 1'b0;
  logic      rst_n;
  logic      ena;
  pin_byte_t ui_in;
  pin_byte_t uio_in;
  pin_byte_t uo_out;
  pin_byte_t uio_out;
  pin_byte_t uio_oe;

  word_t img [128];  // words 0 to 63 are the memory seen by the cpu
  int    num_frames;
  int    num_writes;
  int    num_stalls;
  int    writes_seen;

  cpu_handler_top dut (
    .clk     (clk),
    .rst_n   (rst_n),
    .ui_in   (ui_in),
    .uio_in  (uio_in),
    .ena     (ena),
    .uo_out  (uo_out),
    .uio_out (uio_out),
    .uio_oe  (uio_oe)
  );

  bind bus_handler cpu_handler_asserts u_asserts (
    .clk    (clk),
    .rst_n  (rst_n),
    .phase  (phase),
    .uio_oe (uio_oe),
    .step   (step)
  );

  always #5 clk = ~clk;

  task automatic end_with_failure();
    $display("RESULT: FAIL");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("Error at %0t ns: %s is %h, expected %h", $time, name, got, exp);
      end_with_failure();
    end
  endtask

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic check_idle(input pin_byte_t exp_out);
    check_value("uo_out", 32'(uo_out), 32'(exp_out));
    check_value("uio_oe", 32'(uio_oe), 32'h0);
  endtask

  // run low while the sequencer sits in phase 0
  task automatic stall_before(input int k);
    int s;
    int idle;
    idle = 0;
    for (s = 0; s < num_stalls; s++) begin
      if (img[STALL_BASE + 2 * s] == 32'(k)) begin
        idle = int'(img[STALL_BASE + 2 * s + 1]);
      end
    end
    if (idle > 0) begin
      ui_in[0] = 1'b0;
      repeat (idle) begin
        next_cycle();
        check_idle(8'h00);  // no frame may start
      end
      ui_in[0] = 1'b1;
    end
  endtask

  task automatic apply_write(input addr_t addr, input word_t data);
    if (writes_seen >= num_writes) begin
      $display("write to %h is beyond the %0d expected writes", addr, num_writes);
      end_with_failure();
    end
    check_value("write address", addr, img[WR_BASE + 2 * writes_seen]);
    check_value("write data", data, img[WR_BASE + 2 * writes_seen + 1]);
    img[addr[7:2]] = data;
    writes_seen++;
  endtask

  // entered and left in phase 0, one cycle after the edge
  task automatic run_frame(input int k);
    addr_t     addr;
    word_t     wdata;
    word_t     rdata;
    pin_byte_t oe_bytes [4];
    logic      is_write;
    int        b;
    stall_before(k);
    for (b = 0; b < 4; b++) begin
      next_cycle();  // phases 1 to 4, lsb first
      addr[8*b +: 8]  = uo_out;
      wdata[8*b +: 8] = uio_out;
      oe_bytes[b]     = uio_oe;
    end
    next_cycle();  // flag phase
    is_write = uo_out[0];
    check_value("uo_out[7:1]", 32'(uo_out[7:1]), 32'h0);
    check_value("uio_oe", 32'(uio_oe), 32'h0);
    for (b = 0; b < 4; b++) begin
      check_value("uio_oe", 32'(oe_bytes[b]), 32'({8{is_write}}));
    end
    check_value("frame address", addr, img[ADDR_BASE + k]);
    if (k == 0) begin
      check_value("first frame address", addr, `RESET_PC);
      check_value("first frame flag", 32'(is_write), 32'h0);
    end
    rdata = is_write ? '0 : img[addr[7:2]];
    for (b = 0; b < 4; b++) begin
      next_cycle();  // phases 6 to 9
      check_value("uio_oe", 32'(uio_oe), 32'h0);
      uio_in = rdata[8*b +: 8];  // sampled on the edge closing this phase
    end
    next_cycle();
    uio_in = 8'h00;
    if (is_write) begin
      apply_write(addr, wdata);
    end
  endtask

  initial begin
    int k;
    rst_n       = 1'b0;
    ena         = 1'b1;
    ui_in       = 8'h01;  // run
    uio_in      = 8'h00;
    writes_seen = 0;
    $readmemh("verification/bus_input.txt", img);
    num_frames = int'(img[CNT_BASE]);
    num_writes = int'(img[CNT_BASE + 1]);
    num_stalls = int'(img[CNT_BASE + 2]);
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;
    check_idle(8'h00);
    check_value("uio_out", 32'(uio_out), 32'h0);
    for (k = 0; k < num_frames; k++) begin
      run_frame(k);
    end
    check_value("write count", 32'(writes_seen), 32'(num_writes));
    repeat (HALT_CYCLES) begin
      next_cycle();
      check_idle(8'h80);  // halted, sequencer parked
    end
    if (dut.u_bus_handler.u_asserts.fail_count == 0) begin
      $display("RESULT: PASS");
      $finish;
    end else begin
      $display("%0d frame protocol assertions failed", dut.u_bus_handler.u_asserts.fail_count);
      end_with_failure();
    end
  end

  initial begin : watchdog
    int limit;
    @(posedge rst_n);
    limit = num_frames * `FRAME_LEN * 2 + HALT_CYCLES;
    repeat (limit) @(posedge clk);
    $display("timeout: the run did not finish within %0d cycles after reset", limit);
    end_with_failure();
  end

endmodule

`default_nettype wire

//--- verification/bus_input.txt
// 32-bit hex words, @ sets the word index: 00-3f memory image, 40 frame/write/stall counts,
// 44 expected writes as (addr data), 50 stalls as (frame idle_cycles), 60 address of each frame
@00
00000005 10000003 2000000C 60000034  // loadi 5, add 3, xor c, jz 34 not taken
40000080 20000004 60000024 000000EE  // store 80, xor 4, jz 24 taken, skipped loadi
F0000000 30000070 10000100 40000084  // skipped halt, load 70, add 100, store 84
5000003C F0000000 7000BEEF 30000084  // jump 3c, skipped halt, skipped no-op, load 84
10000001 40000088 F0000000           // add 1, store 88, halt
@1C
12345678                             // data word at 0x70
@40
00000014 00000003 00000002
@44
00000080 00000004
00000084 12345778
00000088 12345779
@50
00000003 00000007
0000000C 00000004
@60
00000000 00000004 00000008 0000000C 00000010
00000080 00000014 00000018 00000024 00000070
00000028 0000002C 00000084 00000030 0000003C
00000084 00000040 00000044 00000088 00000048

//--- build.f
+incdir+common
common/cpu_pkg.sv
cpu/cpu_decode.sv
cpu/cpu_execute.sv
cpu/cpu_result.sv
cpu/cpu_core.sv
source/bus_handler.sv
source/cpu_handler_top.sv
verification/cpu_handler_asserts.sv
verification/tb_cpu_handler.sv

//--- Makefile
# verilator build and run of the tile cpu testbench

VERILATOR ?= verilator
TOP       ?= tb_cpu_handler
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
SOURCES   := $(shell grep -v '^+' $(FILELIST)) common/cpu_defs.svh
SIM       := $(OBJ_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "RESULT: FAIL" $(LOG); then echo "simulation reported a failure"; exit 1; fi
	@if ! grep -q "RESULT: PASS" $(LOG); then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
